// File: rtl/rv_pipe_pkg.sv
// shared widths, operation enum and pipeline stage structs, imported by every rv_pipe module
package rv_pipe_pkg;

  localparam int xlen = 32;

  typedef logic [4:0]      reg_addr_t;
  typedef logic [xlen-1:0] word_t;

  typedef enum logic [2:0] {
    op_nop,
    op_add,
    op_sub,
    op_addi,
    op_lw,
    op_sw,
    op_beq
  } op_e;

  typedef struct packed {
    word_t pc;
    word_t inst;
  } if_id_t;

  typedef struct packed {
    op_e       op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     imm;
    word_t     pc;
    logic      reg_write;
  } id_ex_t;

  typedef struct packed {
    op_e       op;
    reg_addr_t rd;
    word_t     alu_result;
    word_t     store_data;
    logic      reg_write;
  } ex_mem_t;

  typedef struct packed {
    reg_addr_t rd;
    word_t     wdata;
    logic      reg_write;
  } mem_wb_t;

  // what a later stage offers to the forwarding muxes
  typedef struct packed {
    logic      valid;
    logic      reg_write;
    reg_addr_t rd;
    word_t     data;
  } fwd_src_t;

endpackage

// File: rtl/fetch_unit.sv
// instruction fetch: pc register, imem valid/ready requests and branch redirect handling
`timescale 1ns/1ps

module fetch_unit import rv_pipe_pkg::*; #(
  parameter word_t RESET_PC = 32'h0000_0000
) (
  input  logic   clock,
  input  logic   reset,
  input  logic   id_allowin,
  input  logic   redirect,
  input  word_t  redirect_pc,
  input  logic   imem_ready,
  input  word_t  imem_rdata,
  output logic   imem_valid,
  output word_t  imem_addr,
  output logic   fetch_valid,
  output if_id_t fetch_out
);

  typedef enum logic [1:0] {
    fetch_req,
    fetch_hold,
    fetch_discard
  } fetch_state_e;

  fetch_state_e state;
  word_t        pc;
  word_t        inst_q;
  logic         xfer;
  word_t        next_pc;
  word_t        req_pc;

  assign xfer    = imem_valid && imem_ready;
  assign next_pc = redirect ? redirect_pc : pc + 32'd4;
  assign req_pc  = redirect ? redirect_pc : pc;

  // the word is usable in its transfer cycle, or later from the holding register
  assign fetch_valid    = (state == fetch_hold) || (state == fetch_req && xfer);
  assign fetch_out.pc   = pc;
  assign fetch_out.inst = (state == fetch_hold) ? inst_q : imem_rdata;

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= fetch_req;
      pc         <= RESET_PC;
      imem_valid <= 1'b0;
    end else begin
      case (state)
        fetch_req: begin
          if (!imem_valid) begin
            imem_valid <= 1'b1;
            imem_addr  <= req_pc;
            pc         <= req_pc;
          end else if (xfer) begin
            if (redirect || id_allowin) begin
              pc        <= next_pc;
              imem_addr <= next_pc;
            end else begin
              imem_valid <= 1'b0;
              inst_q     <= imem_rdata;
              state      <= fetch_hold;
            end
          end else if (redirect) begin
            pc    <= redirect_pc;
            state <= fetch_discard;
          end
        end
        fetch_discard: begin
          // stale word arrives here and is dropped
          pc <= req_pc;
          if (xfer) begin
            imem_addr <= req_pc;
            state     <= fetch_req;
          end
        end
        fetch_hold: begin
          if (redirect || id_allowin) begin
            pc         <= next_pc;
            imem_valid <= 1'b1;
            imem_addr  <= next_pc;
            state      <= fetch_req;
          end
        end
        default: state <= fetch_req;
      endcase
    end
  end

  a_imem_addr_stable: assert property (
    @(posedge clock) disable iff (reset)
    imem_valid && !imem_ready |=> imem_valid && $stable(imem_addr)
  );

endmodule

// File: rtl/decode_unit.sv
// instruction decode: opcode mapping, immediates and register read addresses
`timescale 1ns/1ps

module decode_unit import rv_pipe_pkg::*; (
  input  if_id_t    id_in,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  output reg_addr_t rs1,
  output reg_addr_t rs2,
  output id_ex_t    id_out
);

  localparam logic [6:0] opc_reg    = 7'b0110011;
  localparam logic [6:0] opc_imm    = 7'b0010011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_branch = 7'b1100011;

  word_t      inst;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rd;
  op_e        op;
  word_t      imm;

  assign inst   = id_in.inst;
  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign rd     = inst[11:7];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];

  always_comb begin
    op = op_nop;
    case (opcode)
      opc_reg: begin
        if (funct3 == 3'b000 && funct7 == 7'b0000000) op = op_add;
        if (funct3 == 3'b000 && funct7 == 7'b0100000) op = op_sub;
      end
      opc_imm:    if (funct3 == 3'b000) op = op_addi;
      opc_load:   if (funct3 == 3'b010) op = op_lw;
      opc_store:  if (funct3 == 3'b010) op = op_sw;
      opc_branch: if (funct3 == 3'b000) op = op_beq;
      default:    op = op_nop;
    endcase
  end

  // I, S or B type, sign extended
  always_comb begin
    case (op)
      op_addi, op_lw: imm = {{20{inst[31]}}, inst[31:20]};
      op_sw:          imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      op_beq:         imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      default:        imm = '0;
    endcase
  end

  always_comb begin
    id_out.op        = op;
    id_out.rd        = rd;
    id_out.rs1       = rs1;
    id_out.rs2       = rs2;
    id_out.rs1_data  = rs1_data;
    id_out.rs2_data  = rs2_data;
    id_out.imm       = imm;
    id_out.pc        = id_in.pc;
    id_out.reg_write = (op == op_add || op == op_sub || op == op_addi || op == op_lw) &&
                       (rd != 5'd0);
  end

endmodule

// File: rtl/hazard_forward.sv
// load-use stall detection and execute operand forwarding
`timescale 1ns/1ps

module hazard_forward import rv_pipe_pkg::*; (
  input  reg_addr_t id_rs1,
  input  reg_addr_t id_rs2,
  input  logic      ex_valid,
  input  op_e       ex_op,
  input  reg_addr_t ex_rd,
  input  reg_addr_t ex_rs1,
  input  reg_addr_t ex_rs2,
  input  word_t     ex_rs1_data,
  input  word_t     ex_rs2_data,
  input  fwd_src_t  mem_fwd,
  input  fwd_src_t  wb_fwd,
  output logic      stall,
  output word_t     rs1_value,
  output word_t     rs2_value
);

  function automatic logic hit(fwd_src_t src, reg_addr_t rs);
    return src.valid && src.reg_write && (src.rd != 5'd0) && (src.rd == rs);
  endfunction

  // youngest result wins
  function automatic word_t pick(reg_addr_t rs, word_t reg_val, fwd_src_t m, fwd_src_t w);
    if (hit(m, rs)) return m.data;
    if (hit(w, rs)) return w.data;
    return reg_val;
  endfunction

  assign stall = ex_valid && (ex_op == op_lw) && (ex_rd != 5'd0) &&
                 ((ex_rd == id_rs1) || (ex_rd == id_rs2));

  assign rs1_value = pick(ex_rs1, ex_rs1_data, mem_fwd, wb_fwd);
  assign rs2_value = pick(ex_rs2, ex_rs2_data, mem_fwd, wb_fwd);

endmodule

// File: rtl/reg_file.sv
// integer register file, two read ports with write-through and one write port
`timescale 1ns/1ps

module reg_file import rv_pipe_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  logic      wr_en,
  input  reg_addr_t wr_addr,
  input  word_t     wr_data,
  output word_t     rs1_data,
  output word_t     rs2_data
);

  word_t regs [1:31];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) regs[i] <= '0;
    end else if (wr_en && wr_addr != 5'd0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // x0 reads zero, same-cycle write is visible
  assign rs1_data = (rs1 == 5'd0) ? '0 : (wr_en && wr_addr == rs1) ? wr_data : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : (wr_en && wr_addr == rs2) ? wr_data : regs[rs2];

endmodule

// File: rtl/execute_unit.sv
// execute stage: ALU, address generation and branch compare/target
`timescale 1ns/1ps

module execute_unit import rv_pipe_pkg::*; (
  input  id_ex_t  ex_in,
  input  logic    ex_valid,
  input  word_t   rs1_value,
  input  word_t   rs2_value,
  output ex_mem_t ex_out,
  output logic    redirect,
  output word_t   redirect_pc
);

  word_t alu_result;

  always_comb begin
    case (ex_in.op)
      op_add:                alu_result = rs1_value + rs2_value;
      op_sub:                alu_result = rs1_value - rs2_value;
      op_addi, op_lw, op_sw: alu_result = rs1_value + ex_in.imm;
      default:               alu_result = '0;
    endcase
  end

  always_comb begin
    ex_out.op         = ex_in.op;
    ex_out.rd         = ex_in.rd;
    ex_out.alu_result = alu_result;
    ex_out.store_data = rs2_value;
    ex_out.reg_write  = ex_in.reg_write;
  end

  assign redirect    = ex_valid && (ex_in.op == op_beq) && (rs1_value == rs2_value);
  assign redirect_pc = ex_in.pc + ex_in.imm;

endmodule

// File: rtl/mem_access.sv
// memory stage: one dmem valid/ready access per LW or SW, load data held until handoff
`timescale 1ns/1ps

module mem_access import rv_pipe_pkg::*; (
  input  logic    clock,
  input  logic    reset,
  input  ex_mem_t mem_in,
  input  logic    mem_valid,
  input  logic    dmem_ready,
  input  word_t   dmem_rdata,
  output logic    dmem_valid,
  output logic    dmem_write,
  output word_t   dmem_addr,
  output word_t   dmem_wdata,
  output logic    mem_done,
  output mem_wb_t mem_out
);

  typedef enum logic [1:0] {
    mem_idle,
    mem_busy,
    mem_done_hold
  } mem_state_e;

  mem_state_e state;
  word_t      load_q;
  logic       is_mem;

  assign is_mem = (mem_in.op == op_lw) || (mem_in.op == op_sw);

  // request goes out in the cycle the instruction arrives
  assign dmem_valid = (state == mem_idle && mem_valid && is_mem) || (state == mem_busy);
  assign dmem_write = dmem_valid && (mem_in.op == op_sw);
  assign dmem_addr  = mem_in.alu_result;
  assign dmem_wdata = mem_in.store_data;
  assign mem_done   = (state == mem_done_hold);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= mem_idle;
    end else begin
      case (state)
        mem_idle: begin
          if (dmem_valid) state <= dmem_ready ? mem_done_hold : mem_busy;
        end
        mem_busy: begin
          if (dmem_ready) state <= mem_done_hold;
        end
        // writeback always takes the instruction here
        mem_done_hold: state <= mem_idle;
        default:       state <= mem_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (dmem_valid && dmem_ready) load_q <= dmem_rdata;
  end

  assign mem_out.rd        = mem_in.rd;
  assign mem_out.wdata     = (mem_in.op == op_lw) ? load_q : mem_in.alu_result;
  assign mem_out.reg_write = mem_in.reg_write;

  a_dmem_req_stable: assert property (
    @(posedge clock) disable iff (reset)
    dmem_valid && !dmem_ready |=>
      dmem_valid && $stable(dmem_addr) && $stable(dmem_write) && $stable(dmem_wdata)
  );

endmodule

// File: rtl/rv_pipe.sv
// five-stage pipeline top: stage registers, valid/allowin chain and unit instances
`timescale 1ns/1ps

module rv_pipe import rv_pipe_pkg::*; #(
  parameter word_t RESET_PC = 32'h0000_0000
) (
  input  logic  clock,
  input  logic  reset,
  input  logic  imem_ready,
  input  word_t imem_rdata,
  input  logic  dmem_ready,
  input  word_t dmem_rdata,
  output logic  imem_valid,
  output word_t imem_addr,
  output logic  dmem_valid,
  output logic  dmem_write,
  output word_t dmem_addr,
  output word_t dmem_wdata
);

  logic      fetch_valid;
  if_id_t    fetch_out;
  if_id_t    id_reg;
  id_ex_t    ex_reg;
  ex_mem_t   mem_reg;
  mem_wb_t   wb_reg;
  logic      id_valid;
  logic      ex_valid;
  logic      mem_valid;
  logic      wb_valid;
  logic      id_allowin;
  logic      ex_allowin;
  logic      mem_allowin;
  logic      id_ready_go;
  logic      mem_ready_go;
  logic      mem_busy;
  logic      mem_done;
  logic      stall;
  logic      redirect;
  logic      flush;
  word_t     redirect_pc;
  reg_addr_t id_rs1;
  reg_addr_t id_rs2;
  word_t     rf_rs1_data;
  word_t     rf_rs2_data;
  id_ex_t    id_out;
  word_t     rs1_value;
  word_t     rs2_value;
  ex_mem_t   ex_out;
  mem_wb_t   mem_out;
  fwd_src_t  mem_fwd;
  fwd_src_t  wb_fwd;

  assign mem_ready_go = !(mem_reg.op == op_lw || mem_reg.op == op_sw) || mem_done;
  // writeback always allows in
  assign mem_allowin  = !mem_valid || mem_ready_go;
  assign mem_busy     = mem_valid && !mem_ready_go;
  // a waiting memory access freezes everything behind it, even an empty execute
  assign ex_allowin   = !mem_busy && (!ex_valid || mem_allowin);
  assign id_ready_go  = !stall;
  assign id_allowin   = !id_valid || (id_ready_go && ex_allowin);

  // branch takes effect only when it leaves execute
  assign flush = redirect && mem_allowin;

  fetch_unit #(.RESET_PC(RESET_PC)) i_fetch (
    .clock      (clock),
    .reset      (reset),
    .id_allowin (id_allowin),
    .redirect   (flush),
    .redirect_pc(redirect_pc),
    .imem_ready (imem_ready),
    .imem_rdata (imem_rdata),
    .imem_valid (imem_valid),
    .imem_addr  (imem_addr),
    .fetch_valid(fetch_valid),
    .fetch_out  (fetch_out)
  );

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      id_valid <= 1'b0;
    end else if (id_allowin) begin
      id_valid <= fetch_valid;
    end
    if (fetch_valid && id_allowin) id_reg <= fetch_out;
  end

  reg_file i_reg_file (
    .clock   (clock),
    .reset   (reset),
    .rs1     (id_rs1),
    .rs2     (id_rs2),
    .wr_en   (wb_valid && wb_reg.reg_write),
    .wr_addr (wb_reg.rd),
    .wr_data (wb_reg.wdata),
    .rs1_data(rf_rs1_data),
    .rs2_data(rf_rs2_data)
  );

  decode_unit i_decode (
    .id_in   (id_reg),
    .rs1_data(rf_rs1_data),
    .rs2_data(rf_rs2_data),
    .rs1     (id_rs1),
    .rs2     (id_rs2),
    .id_out  (id_out)
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      ex_valid <= 1'b0;
    end else if (ex_allowin) begin
      ex_valid <= id_valid && id_ready_go && !flush;
    end
    if (id_valid && id_ready_go && ex_allowin) begin
      ex_reg <= id_out;
    end else begin
      // keep the forwarded operands so a write that retires meanwhile is not lost
      ex_reg.rs1_data <= rs1_value;
      ex_reg.rs2_data <= rs2_value;
    end
  end

  assign mem_fwd.valid     = mem_valid;
  assign mem_fwd.reg_write = mem_reg.reg_write && (mem_reg.op != op_lw);
  assign mem_fwd.rd        = mem_reg.rd;
  assign mem_fwd.data      = mem_reg.alu_result;
  assign wb_fwd.valid      = wb_valid;
  assign wb_fwd.reg_write  = wb_reg.reg_write;
  assign wb_fwd.rd         = wb_reg.rd;
  assign wb_fwd.data       = wb_reg.wdata;

  hazard_forward i_hazard (
    .id_rs1     (id_rs1),
    .id_rs2     (id_rs2),
    .ex_valid   (ex_valid),
    .ex_op      (ex_reg.op),
    .ex_rd      (ex_reg.rd),
    .ex_rs1     (ex_reg.rs1),
    .ex_rs2     (ex_reg.rs2),
    .ex_rs1_data(ex_reg.rs1_data),
    .ex_rs2_data(ex_reg.rs2_data),
    .mem_fwd    (mem_fwd),
    .wb_fwd     (wb_fwd),
    .stall      (stall),
    .rs1_value  (rs1_value),
    .rs2_value  (rs2_value)
  );

  execute_unit i_execute (
    .ex_in      (ex_reg),
    .ex_valid   (ex_valid),
    .rs1_value  (rs1_value),
    .rs2_value  (rs2_value),
    .ex_out     (ex_out),
    .redirect   (redirect),
    .redirect_pc(redirect_pc)
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      mem_valid <= 1'b0;
    end else if (mem_allowin) begin
      mem_valid <= ex_valid;
    end
    if (ex_valid && mem_allowin) mem_reg <= ex_out;
  end

  mem_access i_mem (
    .clock     (clock),
    .reset     (reset),
    .mem_in    (mem_reg),
    .mem_valid (mem_valid),
    .dmem_ready(dmem_ready),
    .dmem_rdata(dmem_rdata),
    .dmem_valid(dmem_valid),
    .dmem_write(dmem_write),
    .dmem_addr (dmem_addr),
    .dmem_wdata(dmem_wdata),
    .mem_done  (mem_done),
    .mem_out   (mem_out)
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= mem_valid && mem_ready_go;
    end
    if (mem_valid && mem_ready_go) wb_reg <= mem_out;
  end

  // the instruction on the data bus stays put until its access ends
  a_ex_mem_hold: assert property (
    @(posedge clock) disable iff (reset)
    dmem_valid |=> mem_valid && $stable(mem_reg)
  );

endmodule

// File: include/test_program.svh
// test program and expected store list, included inside the rv_pipe testbench module
`ifndef TEST_PROGRAM_SVH
`define TEST_PROGRAM_SVH

localparam int prog_len = 17;

localparam logic [31:0] prog_words [prog_len] = '{
  32'h00500093,  // addi x1, x0, 5
  32'h00108133,  // add  x2, x1, x1
  32'h401101b3,  // sub  x3, x2, x1
  32'h00202023,  // sw   x2, 0(x0)
  32'h00302223,  // sw   x3, 4(x0)
  32'h07700313,  // addi x6, x0, 0x77
  32'h00602423,  // sw   x6, 8(x0)
  32'h00802203,  // lw   x4, 8(x0)
  32'h004202b3,  // add  x5, x4, x4
  32'h00502623,  // sw   x5, 12(x0)
  32'h00208463,  // beq  x1, x2, +8 (not taken)
  32'h00102823,  // sw   x1, 16(x0)
  32'h5ad00393,  // addi x7, x0, 0x5ad
  32'h00000463,  // beq  x0, x0, +8 (taken)
  32'h00702a23,  // sw   x7, 20(x0) skipped
  32'h00102c23,  // sw   x1, 24(x0)
  32'h00000063   // beq  x0, x0, 0 end loop
};

localparam int store_count = 6;

localparam logic [31:0] store_addrs [store_count] = '{
  32'd0, 32'd4, 32'd8, 32'd12, 32'd16, 32'd24
};

localparam logic [31:0] store_values [store_count] = '{
  32'd10, 32'd5, 32'h77, 32'hee, 32'd5, 32'd5
};

localparam logic [31:0] poison_addr  = 32'd20;
localparam logic [31:0] poison_value = 32'h5ad;

`endif

// File: tests/rv_pipe_tb.sv
// testbench for rv_pipe: bus models with random ready, bus and store checks, end-of-run report
`timescale 1ns/1ps

module rv_pipe_tb import rv_pipe_pkg::*; ();

  `include "test_program.svh"

  localparam word_t reset_pc        = 32'h0000_0100;
  localparam int    imem_words      = prog_len + 4;
  localparam int    dmem_words      = 16;
  localparam int    prog_index_bits = $clog2(prog_len);
  localparam int    dmem_index_bits = $clog2(dmem_words);
  localparam int    timeout_cycles  = prog_len * 4 * 4 * 4;
  localparam word_t end_pc          = reset_pc + 4 * (prog_len - 1);
  localparam int    test_count      = 5;

  logic  clock;
  logic  reset;
  logic  imem_ready;
  word_t imem_rdata;
  logic  dmem_ready;
  word_t dmem_rdata;
  logic  imem_valid;
  word_t imem_addr;
  logic  dmem_valid;
  logic  dmem_write;
  word_t dmem_addr;
  word_t dmem_wdata;

  word_t data_mem [dmem_words];
  word_t store_addr_q [$];
  word_t store_data_q [$];
  int    test_errors [test_count];
  string test_names [test_count] = '{
    "reset and first fetch", "forwarding chain", "load-use stall", "branches", "back-pressure"
  };
  int    reset_cycles;
  int    fetch_count;
  int    end_fetches;
  int    imem_wait_cycles;
  int    dmem_wait_cycles;
  logic  imem_pending;
  word_t imem_pending_addr;
  logic  dmem_pending;
  logic  dmem_pending_write;
  word_t dmem_pending_addr;
  word_t dmem_pending_wdata;

  rv_pipe #(.RESET_PC(reset_pc)) i_dut (
    .clock     (clock),
    .reset     (reset),
    .imem_ready(imem_ready),
    .imem_rdata(imem_rdata),
    .dmem_ready(dmem_ready),
    .dmem_rdata(dmem_rdata),
    .imem_valid(imem_valid),
    .imem_addr (imem_addr),
    .dmem_valid(dmem_valid),
    .dmem_write(dmem_write),
    .dmem_addr (dmem_addr),
    .dmem_wdata(dmem_wdata)
  );

  function automatic word_t next_random(input word_t state);
    word_t s;
    s = state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic word_t itype_imm(input word_t w);
    return {{20{w[31]}}, w[31:20]};
  endfunction

  function automatic word_t stype_imm(input word_t w);
    return {{20{w[31]}}, w[31:25], w[11:7]};
  endfunction

  // past the program the fetch sees addi x0, x0, 0
  function automatic word_t fetch_word(input word_t addr);
    word_t offset;
    offset = addr - reset_pc;
    if (addr >= reset_pc && offset < 4 * prog_len) begin
      return prog_words[offset[prog_index_bits+1:2]];
    end
    return 32'h0000_0013;
  endfunction

  task automatic value_mismatch(input int test, input string name, input word_t got,
                                input word_t expected);
    $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, expected);
    test_errors[test]++;
  endtask

  task automatic plain_failure(input int test, input string what);
    $display("test %0d check failed: %s", test + 1, what);
    test_errors[test]++;
  endtask

  task automatic verify_store(input int test, input word_t addr, input word_t expected);
    int hits;
    hits = 0;
    foreach (store_addr_q[i]) begin
      if (store_addr_q[i] == addr) begin
        hits++;
        assert (store_data_q[i] == expected)
          else value_mismatch(test, "dmem_wdata", store_data_q[i], expected);
      end
    end
    assert (hits == 1)
      else plain_failure(test, $sformatf("expected one store to 0x%08h, saw %0d", addr, hits));
  endtask

  task automatic compare_store_list();
    int n;
    n = store_addr_q.size();
    assert (n == store_count) else value_mismatch(4, "store count", n, store_count);
    for (int i = 0; i < n && i < store_count; i++) begin
      assert (store_addr_q[i] == store_addrs[i])
        else value_mismatch(4, "dmem_addr", store_addr_q[i], store_addrs[i]);
      assert (store_data_q[i] == store_values[i])
        else value_mismatch(4, "dmem_wdata", store_data_q[i], store_values[i]);
    end
    assert (imem_wait_cycles > 0 && dmem_wait_cycles > 0)
      else plain_failure(4, "ready was never held low on one of the buses");
  endtask

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // memory models, inputs change 1 ns after the edge
  initial begin : bus_driver
    word_t      rng;
    logic [1:0] imem_wait;
    logic [1:0] dmem_wait;
    rng        = 32'h3d3ca694;
    imem_wait  = 2'd0;
    dmem_wait  = 2'd0;
    imem_ready = 1'b0;
    imem_rdata = '0;
    dmem_ready = 1'b0;
    dmem_rdata = '0;
    for (int i = 0; i < dmem_words; i++) begin
      data_mem[i] = 32'ha5a5_0000 ^ word_t'(i << 2);
    end
    forever begin
      @(posedge clock);
      if (imem_valid && imem_ready) begin
        rng       = next_random(rng);
        imem_wait = rng[1:0];
      end
      if (dmem_valid && dmem_ready) begin
        if (dmem_write) data_mem[dmem_addr[dmem_index_bits+1:2]] = dmem_wdata;
        rng       = next_random(rng);
        dmem_wait = rng[1:0];
      end
      #1;
      imem_ready = (imem_wait == 2'd0);
      if (imem_valid && imem_wait != 2'd0) imem_wait--;
      imem_rdata = fetch_word(imem_addr);
      dmem_ready = (dmem_wait == 2'd0);
      if (dmem_valid && dmem_wait != 2'd0) dmem_wait--;
      dmem_rdata = data_mem[dmem_addr[dmem_index_bits+1:2]];
    end
  end

  always @(posedge clock) begin
    if (reset) begin
      // registers are unknown until the first reset edge
      if (reset_cycles > 0) begin
        assert (!imem_valid && !dmem_valid && !dmem_write)
          else plain_failure(0, "a bus valid was raised during reset");
      end
      reset_cycles++;
    end else begin
      if (imem_pending) begin
        assert (imem_valid) else plain_failure(4, "imem_valid dropped before its transfer");
        assert (imem_addr == imem_pending_addr)
          else value_mismatch(4, "imem_addr", imem_addr, imem_pending_addr);
      end
      if (dmem_pending) begin
        assert (dmem_valid) else plain_failure(4, "dmem_valid dropped before its transfer");
        assert (dmem_addr == dmem_pending_addr)
          else value_mismatch(4, "dmem_addr", dmem_addr, dmem_pending_addr);
        assert (dmem_write == dmem_pending_write)
          else value_mismatch(4, "dmem_write", dmem_write, dmem_pending_write);
        assert (dmem_wdata == dmem_pending_wdata)
          else value_mismatch(4, "dmem_wdata", dmem_wdata, dmem_pending_wdata);
      end
      imem_pending       = imem_valid && !imem_ready;
      imem_pending_addr  = imem_addr;
      dmem_pending       = dmem_valid && !dmem_ready;
      dmem_pending_write = dmem_write;
      dmem_pending_addr  = dmem_addr;
      dmem_pending_wdata = dmem_wdata;
      if (imem_pending) imem_wait_cycles++;
      if (dmem_pending) dmem_wait_cycles++;

      if (imem_valid && imem_ready) begin
        if (fetch_count == 0) begin
          assert (imem_addr == reset_pc) else value_mismatch(0, "imem_addr", imem_addr, reset_pc);
        end
        // speculative fetch may run a few words past the end loop
        assert (imem_addr[1:0] == 2'b00 && imem_addr >= reset_pc &&
                imem_addr - reset_pc < 4 * imem_words)
          else plain_failure(0, $sformatf("fetch from 0x%08h outside the program", imem_addr));
        fetch_count++;
        if (imem_addr == end_pc) end_fetches++;
      end

      if (dmem_valid && dmem_ready) begin
        assert (dmem_addr[1:0] == 2'b00 && dmem_addr < 4 * dmem_words)
          else plain_failure(4, $sformatf("data access to 0x%08h outside memory", dmem_addr));
        if (dmem_write) begin
          store_addr_q.push_back(dmem_addr);
          store_data_q.push_back(dmem_wdata);
          assert (dmem_addr != poison_addr && dmem_wdata != poison_value)
            else plain_failure(3, "the store behind the taken branch reached the data bus");
        end
      end
    end
  end

  initial begin : watchdog
    repeat (5 + timeout_cycles) @(posedge clock);
    $display("timeout: the end loop was not reached within %0d cycles", timeout_cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin : main
    word_t a;
    word_t c;
    int    passed;
    int    failed;
    reset            = 1'b1;
    reset_cycles     = 0;
    fetch_count      = 0;
    end_fetches      = 0;
    imem_wait_cycles = 0;
    dmem_wait_cycles = 0;
    imem_pending     = 1'b0;
    dmem_pending     = 1'b0;
    passed           = 0;
    failed           = 0;
    foreach (test_errors[t]) test_errors[t] = 0;
    repeat (5) @(posedge clock);
    #1 reset = 1'b0;

    // third fetch of the end loop means its first pass has redirected
    wait (end_fetches >= 3);

    a = itype_imm(prog_words[0]);
    c = itype_imm(prog_words[5]);
    verify_store(1, stype_imm(prog_words[3]), a + a);
    verify_store(1, stype_imm(prog_words[4]), (a + a) - a);
    verify_store(2, stype_imm(prog_words[9]), c + c);
    verify_store(3, stype_imm(prog_words[11]), a);
    compare_store_list();

    for (int t = 0; t < test_count; t++) begin
      if (test_errors[t] == 0) begin
        passed++;
        $display("test %0d, %s: passed", t + 1, test_names[t]);
      end else begin
        failed++;
        $display("test %0d, %s: failed with %0d errors", t + 1, test_names[t], test_errors[t]);
      end
    end
    $display("tests: %0d, passed: %0d, failed: %0d", test_count, passed, failed);
    if (failed == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: rv_pipe.f
+incdir+include
rtl/rv_pipe_pkg.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/hazard_forward.sv
rtl/reg_file.sv
rtl/execute_unit.sv
rtl/mem_access.sv
rtl/rv_pipe.sv
tests/rv_pipe_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the rv_pipe testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module rv_pipe_tb \
  -f rv_pipe.f -Mdir obj_dir -o rv_pipe_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status, see build.log"
  exit 1
fi

./obj_dir/rv_pipe_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^SIMULATION PASSED$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
